//--- hdl/wq_pkg.sv
package wq_pkg;

  //////////////////////////////////////////////////
  // vector types
  typedef logic [7:0]   qp_idx_t;
  typedef logic [23:0]  qpn_t;
  typedef logic [31:0]  sq_idx_t;
  typedef logic [63:0]  addr_t;
  typedef logic [31:0]  len_t;
  typedef logic [511:0] wqe_t;

  //////////////////////////////////////////////////
  // transport opcodes
  typedef enum logic [4:0] {
    RC_SEND_FIRST        = 5'h00,
    RC_SEND_MIDDLE       = 5'h01,
    RC_SEND_LAST         = 5'h02,
    RC_SEND_ONLY         = 5'h04,
    RC_RDMA_WRITE_FIRST  = 5'h06,
    RC_RDMA_WRITE_MIDDLE = 5'h07,
    RC_RDMA_WRITE_LAST   = 5'h08,
    RC_RDMA_WRITE_ONLY   = 5'h0A,
    RC_RDMA_READ_REQUEST = 5'h0C
  } rdma_op_t;

  // opcode byte as found in the wqe
  localparam logic [7:0] WQE_OP_WRITE = 8'h00;
  localparam logic [7:0] WQE_OP_SEND  = 8'h02;
  localparam logic [7:0] WQE_OP_READ  = 8'h04;

  //////////////////////////////////////////////////
  // wqe layout, low bit of each field
  localparam int unsigned WQE_OP_LSB     = 128;
  localparam int unsigned WQE_LEN_LSB    = 96;
  localparam int unsigned WQE_LADDR_LSB  = 32;
  localparam int unsigned WQE_RVADDR_LSB = 160;

  localparam int unsigned WQE_BYTES = 64; // sq stride

  //////////////////////////////////////////////////
  // state machines
  typedef enum logic {AR_IDLE, AR_VALID} ar_state_t;

  typedef enum logic [1:0] {RD_IDLE, RD_READING, RD_DONE} rd_state_t;

  typedef enum logic [1:0] {SEG_IDLE, SEG_BUILD, SEG_VALID, SEG_DONE} seg_state_t;

  typedef enum logic [2:0] {
    SQ_IDLE,
    SQ_CHECK,
    SQ_FETCH,
    SQ_SEGMENT,
    SQ_NEXT
  } sq_state_t;

endpackage

//--- hdl/sq_doorbell_fifo.sv
`timescale 1ns/1ns

module sq_doorbell_fifo #(
  parameter int DB_DEPTH = 8
) (
  input  logic            axis_aclk_i,
  input  logic            axis_rstn_i,

  input  logic            sq_updated_i,
  input  wq_pkg::qp_idx_t qp_idx_i,
  input  wq_pkg::addr_t   sq_base_i,
  input  wq_pkg::sq_idx_t sq_prod_i,
  input  wq_pkg::sq_idx_t cq_head_i,

  input  logic            db_pop_i,
  output logic            db_valid_o,
  output wq_pkg::qp_idx_t db_qp_idx_o,
  output wq_pkg::addr_t   db_base_o,
  output wq_pkg::sq_idx_t db_prod_o,
  output wq_pkg::sq_idx_t db_head_o
);

  localparam int PTR_W = $clog2(DB_DEPTH);

  wq_pkg::qp_idx_t qp_mem   [DB_DEPTH];
  wq_pkg::addr_t   base_mem [DB_DEPTH];
  wq_pkg::sq_idx_t prod_mem [DB_DEPTH];
  wq_pkg::sq_idx_t head_mem [DB_DEPTH];

  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [PTR_W:0]   count;
  logic             full, empty;
  logic             wr_en, rd_en;

  assign full  = (count == (PTR_W+1)'(DB_DEPTH));
  assign empty = (count == '0);
  assign wr_en = sq_updated_i && !full; // pulses while full are lost
  assign rd_en = db_pop_i && !empty;

  always_ff @(posedge axis_aclk_i) begin
    if (wr_en) begin
      qp_mem[wr_ptr]   <= qp_idx_i;
      base_mem[wr_ptr] <= sq_base_i;
      prod_mem[wr_ptr] <= sq_prod_i;
      head_mem[wr_ptr] <= cq_head_i;
    end
  end

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, wraps
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      if (wr_en && !rd_en) count <= count + 1'b1;
      else if (rd_en && !wr_en) count <= count - 1'b1;
    end
  end

  // head entry
  assign db_valid_o  = !empty;
  assign db_qp_idx_o = qp_mem[rd_ptr];
  assign db_base_o   = base_mem[rd_ptr];
  assign db_prod_o   = prod_mem[rd_ptr];
  assign db_head_o   = head_mem[rd_ptr];

endmodule

//--- hdl/wqe_fetch.sv
`timescale 1ns/1ns

module wqe_fetch (
  input  logic          axis_aclk_i,
  input  logic          axis_rstn_i,

  input  logic          fetch_start_i,
  input  wq_pkg::addr_t fetch_addr_i,
  output logic          fetch_done_o,
  output wq_pkg::wqe_t  wqe_o,

  output wq_pkg::addr_t araddr_o,
  output logic          arvalid_o,
  input  logic          arready_i,

  output logic          rready_o,
  input  logic          rvalid_i,
  input  wq_pkg::wqe_t  rdata_i,
  input  logic          rlast_i
);

  wq_pkg::ar_state_t ar_state;
  wq_pkg::rd_state_t rd_state;
  wq_pkg::addr_t     araddr_q;
  wq_pkg::wqe_t      wqe_q;
  logic              ar_done;
  logic              beat;

  assign ar_done = (ar_state == wq_pkg::AR_VALID) && arready_i;
  assign beat    = (rd_state == wq_pkg::RD_READING) && rvalid_i;

  //////////////////////////////////////////////////
  // address phase
  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      ar_state <= wq_pkg::AR_IDLE;
    end else begin
      case (ar_state)
        wq_pkg::AR_IDLE:  if (fetch_start_i) ar_state <= wq_pkg::AR_VALID;
        wq_pkg::AR_VALID: if (arready_i) ar_state <= wq_pkg::AR_IDLE;
        default:          ar_state <= wq_pkg::AR_IDLE;
      endcase
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (fetch_start_i && ar_state == wq_pkg::AR_IDLE) araddr_q <= fetch_addr_i;
  end

  //////////////////////////////////////////////////
  // data phase
  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      rd_state <= wq_pkg::RD_IDLE;
    end else begin
      case (rd_state)
        wq_pkg::RD_IDLE:    if (ar_done) rd_state <= wq_pkg::RD_READING;
        wq_pkg::RD_READING: if (beat && rlast_i) rd_state <= wq_pkg::RD_DONE;
        default:            rd_state <= wq_pkg::RD_IDLE; // done lasts one cycle
      endcase
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (beat) wqe_q <= rdata_i; // single beat expected, last one wins
  end

  assign araddr_o     = araddr_q;
  assign arvalid_o    = (ar_state == wq_pkg::AR_VALID);
  assign rready_o     = (rd_state == wq_pkg::RD_READING);
  assign fetch_done_o = (rd_state == wq_pkg::RD_DONE);
  assign wqe_o        = wqe_q;

endmodule

//--- hdl/wqe_segmenter.sv
`timescale 1ns/1ns

module wqe_segmenter #(
  parameter int MTU_BYTES = 4096
) (
  input  logic             axis_aclk_i,
  input  logic             axis_rstn_i,

  input  logic             seg_start_i,
  input  wq_pkg::qpn_t     qpn_i,
  input  wq_pkg::wqe_t     wqe_i,
  output logic             seg_done_o,

  output logic             req_valid_o,
  input  logic             req_ready_i,
  output wq_pkg::rdma_op_t req_opcode_o,
  output wq_pkg::qpn_t     req_qpn_o,
  output logic             req_last_o,
  output wq_pkg::addr_t    req_remote_vaddr_o,
  output wq_pkg::addr_t    req_local_addr_o,
  output wq_pkg::len_t     req_len_o
);

  localparam wq_pkg::len_t  MTU_LEN  = wq_pkg::len_t'(MTU_BYTES);
  localparam wq_pkg::addr_t MTU_ADDR = wq_pkg::addr_t'(MTU_BYTES);

  wq_pkg::seg_state_t state;
  logic               first_q;
  wq_pkg::len_t       rem_q;
  wq_pkg::addr_t      laddr_q, raddr_q;

  logic [7:0]         wqe_op;
  logic               is_write, is_send, is_read, op_known;
  wq_pkg::len_t       cur_rem, seg_len;
  wq_pkg::addr_t      cur_laddr, cur_raddr;
  logic               seg_last;
  wq_pkg::rdma_op_t   seg_op;
  logic               load_seg;

  //////////////////////////////////////////////////
  // decode and next segment
  assign wqe_op   = wqe_i[wq_pkg::WQE_OP_LSB +: 8];
  assign is_write = (wqe_op == wq_pkg::WQE_OP_WRITE);
  assign is_send  = (wqe_op == wq_pkg::WQE_OP_SEND);
  assign is_read  = (wqe_op == wq_pkg::WQE_OP_READ);
  assign op_known = is_write || is_send || is_read;

  // first segment works straight from the wqe
  assign cur_rem   = first_q ? wqe_i[wq_pkg::WQE_LEN_LSB +: 32] : rem_q;
  assign cur_laddr = first_q ? wqe_i[wq_pkg::WQE_LADDR_LSB +: 64] : laddr_q;
  assign cur_raddr = first_q ? wqe_i[wq_pkg::WQE_RVADDR_LSB +: 64] : raddr_q;

  always_comb begin
    seg_last = is_read || (cur_rem <= MTU_LEN);
    seg_len  = seg_last ? cur_rem : MTU_LEN; // read keeps the full length
    if (is_read) begin
      seg_op = wq_pkg::RC_RDMA_READ_REQUEST;
    end else if (is_write) begin
      if (first_q && seg_last) seg_op = wq_pkg::RC_RDMA_WRITE_ONLY;
      else if (first_q)        seg_op = wq_pkg::RC_RDMA_WRITE_FIRST;
      else if (seg_last)       seg_op = wq_pkg::RC_RDMA_WRITE_LAST;
      else                     seg_op = wq_pkg::RC_RDMA_WRITE_MIDDLE;
    end else begin
      if (first_q && seg_last) seg_op = wq_pkg::RC_SEND_ONLY;
      else if (first_q)        seg_op = wq_pkg::RC_SEND_FIRST;
      else if (seg_last)       seg_op = wq_pkg::RC_SEND_LAST;
      else                     seg_op = wq_pkg::RC_SEND_MIDDLE;
    end
  end

  assign load_seg = (state == wq_pkg::SEG_BUILD) ||
                    (state == wq_pkg::SEG_IDLE && seg_start_i && op_known);

  //////////////////////////////////////////////////
  // control
  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state   <= wq_pkg::SEG_IDLE;
      first_q <= 1'b1;
    end else begin
      if (load_seg) first_q <= 1'b0;
      case (state)
        wq_pkg::SEG_IDLE: begin
          if (seg_start_i) begin
            state <= op_known ? wq_pkg::SEG_VALID : wq_pkg::SEG_DONE; // unknown op skipped
          end
        end
        wq_pkg::SEG_BUILD: state <= wq_pkg::SEG_VALID;
        wq_pkg::SEG_VALID: begin
          if (req_ready_i) state <= req_last_o ? wq_pkg::SEG_DONE : wq_pkg::SEG_BUILD;
        end
        default: begin
          first_q <= 1'b1;
          state   <= wq_pkg::SEG_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // segment registers
  always_ff @(posedge axis_aclk_i) begin
    if (state == wq_pkg::SEG_IDLE && seg_start_i) req_qpn_o <= qpn_i;
    if (load_seg) begin
      req_opcode_o       <= seg_op;
      req_last_o         <= seg_last;
      req_len_o          <= seg_len;
      req_local_addr_o   <= cur_laddr;
      req_remote_vaddr_o <= is_send ? '0 : cur_raddr; // send has no remote address
      rem_q              <= cur_rem - seg_len;
      laddr_q            <= cur_laddr + MTU_ADDR;
      raddr_q            <= cur_raddr + MTU_ADDR;
    end
  end

  assign req_valid_o = (state == wq_pkg::SEG_VALID);
  assign seg_done_o  = (state == wq_pkg::SEG_DONE);

endmodule

//--- hdl/sq_sequencer.sv
`timescale 1ns/1ns

module sq_sequencer (
  input  logic            axis_aclk_i,
  input  logic            axis_rstn_i,

  input  logic            db_valid_i,
  input  wq_pkg::qp_idx_t db_qp_idx_i,
  input  wq_pkg::addr_t   db_base_i,
  input  wq_pkg::sq_idx_t db_prod_i,
  input  wq_pkg::sq_idx_t db_head_i,
  output logic            db_pop_o,

  output logic            fetch_start_o,
  output wq_pkg::addr_t   fetch_addr_o,
  input  logic            fetch_done_i,

  output logic            seg_start_o,
  output wq_pkg::qpn_t    qpn_o,
  input  logic            seg_done_i
);

  wq_pkg::sq_state_t state;
  wq_pkg::qp_idx_t   qp_q;
  wq_pkg::addr_t     base_q;
  wq_pkg::sq_idx_t   prod_q, head_q;
  wq_pkg::sq_idx_t   idx_q;
  wq_pkg::addr_t     elem_addr;
  logic              fetch_start_q, seg_start_q;

  // element address in the send queue
  assign elem_addr = base_q + wq_pkg::addr_t'(idx_q) * wq_pkg::addr_t'(wq_pkg::WQE_BYTES);

  assign db_pop_o = (state == wq_pkg::SQ_IDLE) && db_valid_i;

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state         <= wq_pkg::SQ_IDLE;
      fetch_start_q <= 1'b0;
      seg_start_q   <= 1'b0;
      idx_q         <= '0;
    end else begin
      fetch_start_q <= 1'b0;
      seg_start_q   <= 1'b0;
      case (state)
        wq_pkg::SQ_IDLE: begin
          if (db_valid_i) state <= wq_pkg::SQ_CHECK;
        end
        wq_pkg::SQ_CHECK: begin
          if (prod_q > head_q) begin
            idx_q <= head_q;
            state <= wq_pkg::SQ_NEXT;
          end else begin
            state <= wq_pkg::SQ_IDLE; // nothing pending
          end
        end
        wq_pkg::SQ_NEXT: begin
          if (idx_q == prod_q) begin
            state <= wq_pkg::SQ_IDLE;
          end else begin
            fetch_start_q <= 1'b1;
            state         <= wq_pkg::SQ_FETCH;
          end
        end
        wq_pkg::SQ_FETCH: begin
          if (fetch_done_i) begin
            seg_start_q <= 1'b1;
            state       <= wq_pkg::SQ_SEGMENT;
          end
        end
        wq_pkg::SQ_SEGMENT: begin
          if (seg_done_i) begin
            idx_q <= idx_q + 1'b1;
            state <= wq_pkg::SQ_NEXT;
          end
        end
        default: state <= wq_pkg::SQ_IDLE;
      endcase
    end
  end

  // doorbell fields and fetch address
  always_ff @(posedge axis_aclk_i) begin
    if (db_pop_o) begin
      qp_q   <= db_qp_idx_i;
      base_q <= db_base_i;
      prod_q <= db_prod_i;
      head_q <= db_head_i;
    end
    if (state == wq_pkg::SQ_NEXT) fetch_addr_o <= elem_addr;
  end

  assign fetch_start_o = fetch_start_q;
  assign seg_start_o   = seg_start_q;
  assign qpn_o         = {16'b0, qp_q};

endmodule

//--- hdl/wq_manager.sv
`timescale 1ns/1ns

module wq_manager #(
  parameter int MTU_BYTES = 4096,
  parameter int DB_DEPTH  = 8
) (
  input  logic             axis_aclk_i,
  input  logic             axis_rstn_i,

  // doorbell
  input  logic             sq_updated_i,
  input  wq_pkg::qp_idx_t  qp_idx_i,
  input  wq_pkg::addr_t    sq_base_i,
  input  wq_pkg::sq_idx_t  sq_prod_i,
  input  wq_pkg::sq_idx_t  cq_head_i,

  // axi read
  output wq_pkg::addr_t    araddr_o,
  output logic             arvalid_o,
  input  logic             arready_i,
  output logic             rready_o,
  input  logic             rvalid_i,
  input  wq_pkg::wqe_t     rdata_i,
  input  logic             rlast_i,

  // transport requests
  output logic             req_valid_o,
  input  logic             req_ready_i,
  output wq_pkg::rdma_op_t req_opcode_o,
  output wq_pkg::qpn_t     req_qpn_o,
  output logic             req_last_o,
  output wq_pkg::addr_t    req_remote_vaddr_o,
  output wq_pkg::addr_t    req_local_addr_o,
  output wq_pkg::len_t     req_len_o
);

  logic            db_valid, db_pop;
  wq_pkg::qp_idx_t db_qp_idx;
  wq_pkg::addr_t   db_base;
  wq_pkg::sq_idx_t db_prod, db_head;
  logic            fetch_start, fetch_done;
  wq_pkg::addr_t   fetch_addr;
  wq_pkg::wqe_t    wqe;
  logic            seg_start, seg_done;
  wq_pkg::qpn_t    qpn;

  sq_doorbell_fifo #(
    .DB_DEPTH(DB_DEPTH)
  ) sq_doorbell_fifo_i (
    .axis_aclk_i (axis_aclk_i),
    .axis_rstn_i (axis_rstn_i),
    .sq_updated_i(sq_updated_i),
    .qp_idx_i    (qp_idx_i),
    .sq_base_i   (sq_base_i),
    .sq_prod_i   (sq_prod_i),
    .cq_head_i   (cq_head_i),
    .db_pop_i    (db_pop),
    .db_valid_o  (db_valid),
    .db_qp_idx_o (db_qp_idx),
    .db_base_o   (db_base),
    .db_prod_o   (db_prod),
    .db_head_o   (db_head)
  );

  sq_sequencer sq_sequencer_i (
    .axis_aclk_i  (axis_aclk_i),
    .axis_rstn_i  (axis_rstn_i),
    .db_valid_i   (db_valid),
    .db_qp_idx_i  (db_qp_idx),
    .db_base_i    (db_base),
    .db_prod_i    (db_prod),
    .db_head_i    (db_head),
    .db_pop_o     (db_pop),
    .fetch_start_o(fetch_start),
    .fetch_addr_o (fetch_addr),
    .fetch_done_i (fetch_done),
    .seg_start_o  (seg_start),
    .qpn_o        (qpn),
    .seg_done_i   (seg_done)
  );

  wqe_fetch wqe_fetch_i (
    .axis_aclk_i  (axis_aclk_i),
    .axis_rstn_i  (axis_rstn_i),
    .fetch_start_i(fetch_start),
    .fetch_addr_i (fetch_addr),
    .fetch_done_o (fetch_done),
    .wqe_o        (wqe),
    .araddr_o     (araddr_o),
    .arvalid_o    (arvalid_o),
    .arready_i    (arready_i),
    .rready_o     (rready_o),
    .rvalid_i     (rvalid_i),
    .rdata_i      (rdata_i),
    .rlast_i      (rlast_i)
  );

  wqe_segmenter #(
    .MTU_BYTES(MTU_BYTES)
  ) wqe_segmenter_i (
    .axis_aclk_i       (axis_aclk_i),
    .axis_rstn_i       (axis_rstn_i),
    .seg_start_i       (seg_start),
    .qpn_i             (qpn),
    .wqe_i             (wqe),
    .seg_done_o        (seg_done),
    .req_valid_o       (req_valid_o),
    .req_ready_i       (req_ready_i),
    .req_opcode_o      (req_opcode_o),
    .req_qpn_o         (req_qpn_o),
    .req_last_o        (req_last_o),
    .req_remote_vaddr_o(req_remote_vaddr_o),
    .req_local_addr_o  (req_local_addr_o),
    .req_len_o         (req_len_o)
  );

endmodule

//--- testbench/wq_manager_assertions.sv
`timescale 1ns/1ns

module wq_manager_assertions (
  input logic             axis_aclk_i,
  input logic             axis_rstn_i,
  input logic             req_valid_o,
  input logic             req_ready_i,
  input wq_pkg::rdma_op_t req_opcode_o,
  input wq_pkg::qpn_t     req_qpn_o,
  input logic             req_last_o,
  input wq_pkg::addr_t    req_remote_vaddr_o,
  input wq_pkg::addr_t    req_local_addr_o,
  input wq_pkg::len_t     req_len_o,
  input wq_pkg::addr_t    araddr_o,
  input logic             arvalid_o,
  input logic             arready_i,
  input logic             rready_o
);

  // stalled request holds
  assert property (@(posedge axis_aclk_i) disable iff (!axis_rstn_i)
    req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_opcode_o) &&
      $stable(req_qpn_o) && $stable(req_last_o) && $stable(req_remote_vaddr_o) &&
      $stable(req_local_addr_o) && $stable(req_len_o))
    else $error("request changed while waiting for ready");

  assert property (@(posedge axis_aclk_i) disable iff (!axis_rstn_i)
    arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
    else $error("read address changed before arready");

  assert property (@(posedge axis_aclk_i)
    !axis_rstn_i |-> !req_valid_o && !arvalid_o && !rready_o)
    else $error("valid or ready high during reset");

endmodule

bind wq_manager wq_manager_assertions wq_manager_assertions_i (.*);

//--- testbench/tb_wq_manager.sv
`timescale 1ns/1ns

module tb_wq_manager;

  localparam int MTU_BYTES = 4096;
  localparam int DB_DEPTH  = 8;
  localparam int NROWS     = 8;
  localparam int MAXW      = 3; // elements per doorbell at most

  typedef struct packed {
    logic [7:0]    op;
    wq_pkg::len_t  len;
    wq_pkg::addr_t laddr;
    wq_pkg::addr_t raddr;
    wq_pkg::qpn_t  qpn;
  } wqe_desc_t;

  typedef struct packed {
    logic [4:0]    opcode;
    logic          last;
    wq_pkg::addr_t raddr;
    wq_pkg::addr_t laddr;
    wq_pkg::len_t  len;
  } seg_t;

  logic             axis_aclk_i;
  logic             axis_rstn_i;
  logic             sq_updated_i;
  wq_pkg::qp_idx_t  qp_idx_i;
  wq_pkg::addr_t    sq_base_i;
  wq_pkg::sq_idx_t  sq_prod_i;
  wq_pkg::sq_idx_t  cq_head_i;
  wq_pkg::addr_t    araddr_o;
  logic             arvalid_o;
  logic             arready_i;
  logic             rready_o;
  logic             rvalid_i;
  wq_pkg::wqe_t     rdata_i;
  logic             rlast_i;
  logic             req_valid_o;
  logic             req_ready_i;
  wq_pkg::rdma_op_t req_opcode_o;
  wq_pkg::qpn_t     req_qpn_o;
  logic             req_last_o;
  wq_pkg::addr_t    req_remote_vaddr_o;
  wq_pkg::addr_t    req_local_addr_o;
  wq_pkg::len_t     req_len_o;

  //////////////////////////////////////////////////
  // case table, one row per doorbell
  wq_pkg::qp_idx_t row_qp    [NROWS];
  wq_pkg::addr_t   row_base  [NROWS];
  wq_pkg::sq_idx_t row_head  [NROWS];
  wq_pkg::sq_idx_t row_prod  [NROWS];
  logic [7:0]      row_op    [NROWS][MAXW];
  wq_pkg::len_t    row_len   [NROWS][MAXW];
  wq_pkg::addr_t   row_laddr [NROWS][MAXW];
  wq_pkg::addr_t   row_raddr [NROWS][MAXW];

  integer          seed = 32'hb9d;
  wq_pkg::addr_t   mem_addr  [$]; // send queue contents, by address
  wq_pkg::wqe_t    mem_data  [$];
  wq_pkg::addr_t   exp_reads [$];
  wqe_desc_t       exp_elems [$];
  int              seg_k = 0;
  int              req_seen = 0;
  int              total_segs = 0;
  int              timeout_cycles = 0;

  wq_manager #(
    .MTU_BYTES(MTU_BYTES),
    .DB_DEPTH (DB_DEPTH)
  ) wq_manager_i (.*);

  initial axis_aclk_i = 1'b0;
  always #10 axis_aclk_i = ~axis_aclk_i;

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(string what, logic [63:0] got, logic [63:0] want);
    if (got !== want) begin
      abort_run($sformatf("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
                          $time, what, got, want));
    end
  endtask

  function automatic logic op_known(logic [7:0] op);
    return op == wq_pkg::WQE_OP_WRITE || op == wq_pkg::WQE_OP_SEND ||
           op == wq_pkg::WQE_OP_READ;
  endfunction

  function automatic int seg_count(logic [7:0] op, wq_pkg::len_t len);
    if (!op_known(op)) return 0;
    if (op == wq_pkg::WQE_OP_READ || len <= MTU_BYTES) return 1;
    return (len + MTU_BYTES - 1) / MTU_BYTES;
  endfunction

  // segment k of an element, from the segmentation rules
  function automatic seg_t calc_segment(wqe_desc_t d, int k);
    seg_t s;
    int   n;
    logic is_send;
    n       = seg_count(d.op, d.len);
    is_send = (d.op == wq_pkg::WQE_OP_SEND);
    s.last  = (k == n - 1);
    s.len   = d.len;
    s.laddr = d.laddr + wq_pkg::addr_t'(k * MTU_BYTES);
    s.raddr = is_send ? '0 : d.raddr + wq_pkg::addr_t'(k * MTU_BYTES);
    if (d.op == wq_pkg::WQE_OP_READ) begin
      s.opcode = wq_pkg::RC_RDMA_READ_REQUEST;
    end else if (n == 1) begin
      s.opcode = is_send ? wq_pkg::RC_SEND_ONLY : wq_pkg::RC_RDMA_WRITE_ONLY;
    end else if (k == 0) begin
      s.opcode = is_send ? wq_pkg::RC_SEND_FIRST : wq_pkg::RC_RDMA_WRITE_FIRST;
      s.len    = MTU_BYTES;
    end else if (s.last) begin
      s.opcode = is_send ? wq_pkg::RC_SEND_LAST : wq_pkg::RC_RDMA_WRITE_LAST;
      s.len    = d.len - wq_pkg::len_t'(k * MTU_BYTES);
    end else begin
      s.opcode = is_send ? wq_pkg::RC_SEND_MIDDLE : wq_pkg::RC_RDMA_WRITE_MIDDLE;
      s.len    = MTU_BYTES;
    end
    return s;
  endfunction

  function automatic wq_pkg::wqe_t make_wqe(logic [7:0] op, wq_pkg::len_t len,
                                            wq_pkg::addr_t laddr, wq_pkg::addr_t raddr);
    wq_pkg::wqe_t w;
    w = '0;
    w[wq_pkg::WQE_OP_LSB +: 8]      = op;
    w[wq_pkg::WQE_LEN_LSB +: 32]    = len;
    w[wq_pkg::WQE_LADDR_LSB +: 64]  = laddr;
    w[wq_pkg::WQE_RVADDR_LSB +: 64] = raddr;
    return w;
  endfunction

  function automatic wq_pkg::wqe_t find_wqe(wq_pkg::addr_t a);
    foreach (mem_addr[i]) begin
      if (mem_addr[i] == a) return mem_data[i];
    end
    return '0;
  endfunction

  task automatic set_row(int r, wq_pkg::qp_idx_t qp, wq_pkg::addr_t base,
                         wq_pkg::sq_idx_t head, wq_pkg::sq_idx_t prod);
    row_qp[r]   = qp;
    row_base[r] = base;
    row_head[r] = head;
    row_prod[r] = prod;
  endtask

  task automatic set_elem(int r, int w, logic [7:0] op, wq_pkg::len_t len,
                          wq_pkg::addr_t laddr, wq_pkg::addr_t raddr);
    row_op[r][w]    = op;
    row_len[r][w]   = len;
    row_laddr[r][w] = laddr;
    row_raddr[r][w] = raddr;
  endtask

  task automatic load_table();
    set_row(0, 8'h03, 64'h0001_0000, 0, 1);
    set_elem(0, 0, wq_pkg::WQE_OP_WRITE, 1000, 64'h8000_0000, 64'h1234_0000_0000);
    set_row(1, 8'h05, 64'h0002_0000, 0, 1);
    set_elem(1, 0, wq_pkg::WQE_OP_WRITE, 10000, 64'h8001_0000, 64'h10_0000_0000);
    set_row(2, 8'h07, 64'h0003_0000, 1, 2);
    set_elem(2, 0, wq_pkg::WQE_OP_SEND, 14000, 64'h8002_0000, 64'hdead_beef_0000);
    set_row(3, 8'h09, 64'h0004_0000, 3, 3); // nothing pending
    set_row(4, 8'h0b, 64'h0005_0000, 0, 1);
    set_elem(4, 0, wq_pkg::WQE_OP_READ, 20000, 64'h8003_0000, 64'h20_0000_0000);
    set_row(5, 8'h0c, 64'h0006_0000, 2, 5);
    set_elem(5, 0, wq_pkg::WQE_OP_WRITE, 4096, 64'h8004_0000, 64'h30_0000_0000);
    set_elem(5, 1, 8'h3f, 512, 64'h8005_0000, 64'h40_0000_0000); // unknown op
    set_elem(5, 2, wq_pkg::WQE_OP_SEND, 100, 64'h8006_0000, 64'h50_0000_0000);
    set_row(6, 8'h0d, 64'h0007_0000, 6, 2); // producer behind head
    set_row(7, 8'h0e, 64'h0008_0000, 0, 2);
    set_elem(7, 0, wq_pkg::WQE_OP_WRITE, 4097, 64'h8007_0000, 64'h60_0000_0000);
    set_elem(7, 1, wq_pkg::WQE_OP_WRITE, 8192, 64'h8008_0000, 64'h70_0000_0000);
  endtask

  // store the row's elements, queue what is expected, ring the doorbell
  task automatic apply_row(int r);
    wq_pkg::sq_idx_t idx;
    wq_pkg::addr_t   a;
    wqe_desc_t       d;
    int              w;
    for (idx = row_head[r]; idx < row_prod[r]; idx++) begin
      w = idx - row_head[r];
      a = row_base[r] + wq_pkg::addr_t'(idx) * wq_pkg::WQE_BYTES;
      mem_addr.push_back(a);
      mem_data.push_back(make_wqe(row_op[r][w], row_len[r][w], row_laddr[r][w],
                                  row_raddr[r][w]));
      exp_reads.push_back(a);
      if (op_known(row_op[r][w])) begin
        d.op    = row_op[r][w];
        d.len   = row_len[r][w];
        d.laddr = row_laddr[r][w];
        d.raddr = row_raddr[r][w];
        d.qpn   = wq_pkg::qpn_t'(row_qp[r]);
        exp_elems.push_back(d);
      end
    end
    @(posedge axis_aclk_i);
    #2;
    sq_updated_i = 1'b1;
    qp_idx_i     = row_qp[r];
    sq_base_i    = row_base[r];
    sq_prod_i    = row_prod[r];
    cq_head_i    = row_head[r];
    @(posedge axis_aclk_i);
    #2;
    sq_updated_i = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // axi slave, one beat per address
  initial begin : axi_slave
    wq_pkg::addr_t a;
    int            delay;
    arready_i = 1'b0;
    rvalid_i  = 1'b0;
    rlast_i   = 1'b0;
    rdata_i   = '0;
    wait (axis_rstn_i === 1'b1);
    forever begin
      @(posedge axis_aclk_i);
      if (arvalid_o && arready_i) begin
        a = araddr_o;
        if (exp_reads.size() == 0)
          abort_run($sformatf("unexpected AXI read at address 0x%0h", a));
        else
          check_value("araddr", a, exp_reads.pop_front());
        delay = 1 + ({$random(seed)} % 3);
        repeat (delay - 1) @(posedge axis_aclk_i);
        #2;
        rvalid_i = 1'b1;
        rlast_i  = 1'b1;
        rdata_i  = find_wqe(a);
        do @(posedge axis_aclk_i); while (!rready_o);
        #2;
        rvalid_i = 1'b0;
        rlast_i  = 1'b0;
        rdata_i  = '0;
      end
    end
  end

  always @(posedge axis_aclk_i) begin
    #2;
    req_ready_i = axis_rstn_i && ({$random(seed)} % 4 != 0); // ready about 3 of 4
    arready_i   = axis_rstn_i && ({$random(seed)} % 2 != 0); // address ready about half
  end

  //////////////////////////////////////////////////
  // request checker
  always @(posedge axis_aclk_i) begin : req_checker
    wqe_desc_t d;
    seg_t      want;
    if (axis_rstn_i && req_valid_o && req_ready_i) begin
      if (exp_elems.size() == 0) begin
        abort_run($sformatf("request 0x%0h sent with no element pending", req_opcode_o));
      end else begin
        d    = exp_elems[0];
        want = calc_segment(d, seg_k);
        check_value("opcode", req_opcode_o, want.opcode);
        check_value("qpn", req_qpn_o, d.qpn);
        check_value("last", req_last_o, want.last);
        check_value("len", req_len_o, want.len);
        check_value("local addr", req_local_addr_o, want.laddr);
        check_value("remote vaddr", req_remote_vaddr_o, want.raddr);
        if (want.last) begin
          void'(exp_elems.pop_front());
          seg_k = 0;
        end else begin
          seg_k++;
        end
        req_seen++;
      end
    end
  end

  initial begin : watchdog
    wait (timeout_cycles > 0);
    repeat (timeout_cycles) @(posedge axis_aclk_i);
    abort_run($sformatf("timeout, %0d of %0d requests seen after %0d cycles",
                        req_seen, total_segs, timeout_cycles));
  end

  initial begin : stimulus
    int r;
    int w;
    axis_rstn_i  = 1'b0;
    sq_updated_i = 1'b0;
    qp_idx_i     = '0;
    sq_base_i    = '0;
    sq_prod_i    = '0;
    cq_head_i    = '0;
    req_ready_i  = 1'b0;
    load_table();
    for (r = 0; r < NROWS; r++) begin
      if (row_prod[r] > row_head[r]) begin
        for (w = 0; w < int'(row_prod[r] - row_head[r]); w++)
          total_segs += seg_count(row_op[r][w], row_len[r][w]);
      end
    end
    timeout_cycles = total_segs * 200;
    repeat (4) @(posedge axis_aclk_i);
    #2;
    axis_rstn_i = 1'b1;
    for (r = 0; r < NROWS; r++) apply_row(r);
    while (req_seen < total_segs || exp_reads.size() != 0) @(posedge axis_aclk_i);
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- filelist.f
hdl/wq_pkg.sv
hdl/sq_doorbell_fifo.sv
hdl/wqe_fetch.sv
hdl/wqe_segmenter.sv
hdl/sq_sequencer.sv
hdl/wq_manager.sv
testbench/wq_manager_assertions.sv
testbench/tb_wq_manager.sv

//--- Bender.yml
package:
  name: wq_manager

sources:
  - hdl/wq_pkg.sv
  - hdl/sq_doorbell_fifo.sv
  - hdl/wqe_fetch.sv
  - hdl/wqe_segmenter.sv
  - hdl/sq_sequencer.sv
  - hdl/wq_manager.sv
  - target: test
    files:
      - testbench/wq_manager_assertions.sv
      - testbench/tb_wq_manager.sv
